/* design/vec_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared sizes, opcodes and the Wishbone register map of the vector
// coprocessor. Design modules import it inside their bodies.
////////////////////////////////////////////////////////////////////////////

package vec_pkg;

  // One element, also the Wishbone data width
  localparam int unsigned ElemWidth = 32;
  typedef logic [ElemWidth-1:0] elem_t;

  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = 3;
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;

  localparam int unsigned WbAddrWidth = 12;
  typedef logic [WbAddrWidth-1:0] wb_addr_t;

  localparam int unsigned OpWidth = 4;
  typedef enum logic [OpWidth-1:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VAND    = 4'd2,
    VOR     = 4'd3,
    VXOR    = 4'd4,
    VADD_VX = 4'd5,
    VMV_VX  = 4'd6,
    VCPOP   = 4'd7
  } vec_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Register map (word addresses)
  ////////////////////////////////////////////////////////////////////////////

  localparam wb_addr_t AddrInsn     = 12'd0;
  localparam wb_addr_t AddrScalar   = 12'd1;
  localparam wb_addr_t AddrResult   = 12'd2;
  localparam wb_addr_t AddrStatus   = 12'd3;
  localparam wb_addr_t AddrElemBase = 12'd256;

  // Element window: register in bits 7:5, element index in bits 4:0
  localparam int unsigned ElemIdxWidth = 5;
  localparam int unsigned ElemRegLsb   = ElemIdxWidth;
  localparam int unsigned ElemWinLsb   = ElemRegLsb + VRegIdxWidth;

  // Instruction word fields
  localparam int unsigned InsnOpLsb  = 0;
  localparam int unsigned InsnVdLsb  = 4;
  localparam int unsigned InsnVs1Lsb = 7;
  localparam int unsigned InsnVs2Lsb = 10;

endpackage : vec_pkg

/* design/vec_dispatcher.sv */
////////////////////////////////////////////////////////////////////////////
// Wishbone front end of the coprocessor. Decodes instruction writes into
// issue requests, keeps the scalar register and routes element accesses
// to the lane that holds the element.
////////////////////////////////////////////////////////////////////////////

module vec_dispatcher #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  vec_pkg::wb_addr_t            wb_adr_i,
  input  vec_pkg::elem_t               wb_dat_i,
  output vec_pkg::elem_t               wb_dat_o,
  output logic                         wb_ack_o,
  // Sequencer
  input  logic                         busy_i,
  output logic                         issue_o,
  output vec_pkg::vec_op_e             issue_op_o,
  output vec_pkg::vreg_idx_t           issue_vd_o,
  output vec_pkg::vreg_idx_t           issue_vs1_o,
  output vec_pkg::vreg_idx_t           issue_vs2_o,
  // Lanes and mask unit
  input  vec_pkg::elem_t [NrLanes-1:0] rd_data_i,
  input  vec_pkg::elem_t               result_i,
  output vec_pkg::elem_t               scalar_o,
  output logic [NrLanes-1:0]           host_we_o,
  output vec_pkg::vreg_idx_t           host_vreg_o,
  output logic [SlotWidth-1:0]         host_slot_o,
  output vec_pkg::elem_t               host_wdata_o
);

  import vec_pkg::*;

  logic                    access;
  logic                    elem_hit;
  logic                    elem_in_range;
  logic [ElemIdxWidth-1:0] elem_idx;
  logic [ElemIdxWidth-1:0] lane_idx;
  logic [ElemIdxWidth-1:0] slot_idx;
  vec_op_e                 insn_op;
  logic                    insn_known;
  logic                    issue_d;
  elem_t                   rdata_d;
  elem_t                   scalar_q;
  logic                    ack_q;
  logic                    issue_q;

  // One accept per handshake, held off while an instruction runs
  assign access = wb_cyc_i & wb_stb_i & ~ack_q & ~busy_i;

  // Element e lives in lane e % NrLanes at slot e / NrLanes
  assign elem_hit = wb_adr_i[WbAddrWidth-1:ElemWinLsb] == AddrElemBase[WbAddrWidth-1:ElemWinLsb];
  assign elem_idx      = wb_adr_i[ElemIdxWidth-1:0];
  assign lane_idx      = ElemIdxWidth'(elem_idx % NrLanes);
  assign slot_idx      = ElemIdxWidth'(elem_idx / NrLanes);
  assign elem_in_range = elem_hit && (32'(elem_idx) < NrLanes * ElemsPerLane);

  assign host_vreg_o  = wb_adr_i[ElemRegLsb +: VRegIdxWidth];
  assign host_slot_o  = slot_idx[SlotWidth-1:0];
  assign host_wdata_o = wb_dat_i;

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      host_we_o[l] = access & wb_we_i & elem_in_range & (lane_idx == ElemIdxWidth'(l));
    end
  end

  // Unknown opcodes are acked and dropped
  always_comb begin
    insn_op = vec_op_e'(wb_dat_i[InsnOpLsb +: OpWidth]);
    case (insn_op)
      VADD, VSUB, VAND, VOR, VXOR, VADD_VX, VMV_VX, VCPOP: insn_known = 1'b1;
      default: insn_known = 1'b0;
    endcase
  end

  assign issue_d = access & wb_we_i & (wb_adr_i == AddrInsn) & insn_known;

  // Read-back mux
  always_comb begin
    rdata_d = '0;
    if (elem_in_range) begin
      rdata_d = rd_data_i[lane_idx];
    end else begin
      case (wb_adr_i)
        AddrScalar: rdata_d = scalar_q;
        AddrResult: rdata_d = result_i;
        AddrStatus: rdata_d = ElemWidth'(busy_i);
        default:    rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q    <= 1'b0;
      issue_q  <= 1'b0;
      scalar_q <= '0;
    end else begin
      ack_q   <= access;
      issue_q <= issue_d;
      if (access && wb_we_i && (wb_adr_i == AddrScalar)) begin
        scalar_q <= wb_dat_i;
      end
    end
  end

  // Read data and instruction fields
  always_ff @(posedge clk_i) begin
    if (access && !wb_we_i) begin
      wb_dat_o <= rdata_d;
    end
    if (issue_d) begin
      issue_op_o  <= insn_op;
      issue_vd_o  <= wb_dat_i[InsnVdLsb +: VRegIdxWidth];
      issue_vs1_o <= wb_dat_i[InsnVs1Lsb +: VRegIdxWidth];
      issue_vs2_o <= wb_dat_i[InsnVs2Lsb +: VRegIdxWidth];
    end
  end

  assign wb_ack_o = ack_q;
  assign issue_o  = issue_q;
  assign scalar_o = scalar_q;

endmodule : vec_dispatcher

/* design/vec_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Steps one issued instruction through the element slots, one slot per
// cycle in every lane at once. Busy while the slots are being walked.
////////////////////////////////////////////////////////////////////////////

module vec_sequencer #(
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Dispatcher
  input  logic                 issue_i,
  input  vec_pkg::vec_op_e     issue_op_i,
  input  vec_pkg::vreg_idx_t   issue_vd_i,
  input  vec_pkg::vreg_idx_t   issue_vs1_i,
  input  vec_pkg::vreg_idx_t   issue_vs2_i,
  output logic                 busy_o,
  // Lanes and mask unit
  output logic                 ex_valid_o,
  output vec_pkg::vec_op_e     ex_op_o,
  output logic [SlotWidth-1:0] ex_slot_o,
  output vec_pkg::vreg_idx_t   ex_vd_o,
  output vec_pkg::vreg_idx_t   ex_vs1_o,
  output vec_pkg::vreg_idx_t   ex_vs2_o,
  output logic                 ex_last_o
);

  import vec_pkg::*;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_e;

  localparam logic [SlotWidth-1:0] LastSlot = SlotWidth'(ElemsPerLane - 1);

  seq_state_e           state_q;
  seq_state_e           state_d;
  logic [SlotWidth-1:0] slot_q;
  logic [SlotWidth-1:0] slot_d;

  always_comb begin
    state_d = state_q;
    slot_d  = slot_q;
    case (state_q)
      SEQ_IDLE: begin
        if (issue_i) begin
          state_d = SEQ_RUN;
          slot_d  = '0;
        end
      end
      SEQ_RUN: begin
        if (slot_q == LastSlot) begin
          state_d = SEQ_IDLE;
        end else begin
          slot_d = slot_q + 1'b1;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SEQ_IDLE;
      slot_q  <= '0;
    end else begin
      state_q <= state_d;
      slot_q  <= slot_d;
    end
  end

  // Instruction is held for the whole run
  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE && issue_i) begin
      ex_op_o  <= issue_op_i;
      ex_vd_o  <= issue_vd_i;
      ex_vs1_o <= issue_vs1_i;
      ex_vs2_o <= issue_vs2_i;
    end
  end

  assign busy_o     = (state_q == SEQ_RUN);
  assign ex_valid_o = (state_q == SEQ_RUN);
  assign ex_slot_o  = slot_q;
  assign ex_last_o  = ex_valid_o & (slot_q == LastSlot);

endmodule : vec_sequencer

/* design/vec_lane.sv */
////////////////////////////////////////////////////////////////////////////
// One lane: its slice of every vector register and an integer ALU.
// Instantiated NrLanes times by the top level.
////////////////////////////////////////////////////////////////////////////

module vec_lane #(
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Sequencer
  input  logic                 ex_valid_i,
  input  vec_pkg::vec_op_e     ex_op_i,
  input  logic [SlotWidth-1:0] ex_slot_i,
  input  vec_pkg::vreg_idx_t   ex_vd_i,
  input  vec_pkg::vreg_idx_t   ex_vs1_i,
  input  vec_pkg::vreg_idx_t   ex_vs2_i,
  input  vec_pkg::elem_t       scalar_i,
  // Host element access
  input  logic                 host_we_i,
  input  vec_pkg::vreg_idx_t   host_vreg_i,
  input  logic [SlotWidth-1:0] host_slot_i,
  input  vec_pkg::elem_t       host_wdata_i,
  output vec_pkg::elem_t       rd_data_o,
  // Mask unit
  output logic                 mask_bit_o
);

  import vec_pkg::*;

  elem_t vrf_q [NrVRegs][ElemsPerLane];
  elem_t vs1_elem;
  elem_t vs2_elem;
  elem_t alu_res;
  logic  alu_we;

  assign vs1_elem  = vrf_q[ex_vs1_i][ex_slot_i];
  assign vs2_elem  = vrf_q[ex_vs2_i][ex_slot_i];
  assign rd_data_o = vrf_q[host_vreg_i][host_slot_i];

  // vcpop looks at bit 0 of vs2 only
  assign mask_bit_o = ex_valid_i & vs2_elem[0];

  // Integer ALU, vd = vs2 op vs1 as in RVV
  always_comb begin
    alu_res = vs2_elem;
    alu_we  = ex_valid_i;
    case (ex_op_i)
      VADD:    alu_res = vs2_elem + vs1_elem;
      VSUB:    alu_res = vs2_elem - vs1_elem;
      VAND:    alu_res = vs2_elem & vs1_elem;
      VOR:     alu_res = vs2_elem | vs1_elem;
      VXOR:    alu_res = vs2_elem ^ vs1_elem;
      VADD_VX: alu_res = vs2_elem + scalar_i;
      VMV_VX:  alu_res = scalar_i;
      default: alu_we  = 1'b0;
    endcase
  end

  // Host writes only happen while the sequencer is idle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (alu_we) begin
      vrf_q[ex_vd_i][ex_slot_i] <= alu_res;
    end else if (host_we_i) begin
      vrf_q[host_vreg_i][host_slot_i] <= host_wdata_i;
    end
  end

endmodule : vec_lane

/* design/vec_masku.sv */
////////////////////////////////////////////////////////////////////////////
// Mask unit. Counts the lane bits of a running vcpop and keeps the
// final count as the scalar result read by the host.
////////////////////////////////////////////////////////////////////////////

module vec_masku #(
  parameter int unsigned NrLanes = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Sequencer
  input  logic               ex_valid_i,
  input  vec_pkg::vec_op_e   ex_op_i,
  input  logic               ex_last_i,
  // Lanes
  input  logic [NrLanes-1:0] lane_bit_i,
  // Dispatcher
  output vec_pkg::elem_t     result_o
);

  import vec_pkg::*;

  logic  active;
  logic  running_q;
  elem_t lane_pop;
  elem_t count_sum;
  elem_t count_q;
  elem_t result_q;

  assign active = ex_valid_i & (ex_op_i == VCPOP);

  // Set bits across the lanes for this slot
  always_comb begin
    lane_pop = '0;
    for (int l = 0; l < NrLanes; l++) begin
      lane_pop = lane_pop + ElemWidth'(lane_bit_i[l]);
    end
  end

  // First slot of a vcpop starts from zero
  assign count_sum = (running_q ? count_q : elem_t'(0)) + lane_pop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= 1'b0;
      count_q   <= '0;
      result_q  <= '0;
    end else if (active) begin
      running_q <= ~ex_last_i;
      count_q   <= count_sum;
      if (ex_last_i) begin
        result_q <= count_sum;
      end
    end
  end

  assign result_o = result_q;

endmodule : vec_masku

/* design/vec_top.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the vector coprocessor. A host reaches it over a Wishbone
// classic slave port. Set NrLanes and ElemsPerLane here.
////////////////////////////////////////////////////////////////////////////

module vec_top #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // Wishbone classic slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  vec_pkg::wb_addr_t wb_adr_i,
  input  vec_pkg::elem_t    wb_dat_i,
  output vec_pkg::elem_t    wb_dat_o,
  output logic              wb_ack_o
);

  import vec_pkg::*;

  // Dispatcher to sequencer
  logic      issue;
  vec_op_e   issue_op;
  vreg_idx_t issue_vd;
  vreg_idx_t issue_vs1;
  vreg_idx_t issue_vs2;
  logic      busy;
  // Sequencer broadcast
  logic                 ex_valid;
  vec_op_e              ex_op;
  logic [SlotWidth-1:0] ex_slot;
  vreg_idx_t            ex_vd;
  vreg_idx_t            ex_vs1;
  vreg_idx_t            ex_vs2;
  logic                 ex_last;
  // Host element access and results
  elem_t                scalar;
  elem_t                result;
  elem_t [NrLanes-1:0]  rd_data;
  logic  [NrLanes-1:0]  host_we;
  vreg_idx_t            host_vreg;
  logic [SlotWidth-1:0] host_slot;
  elem_t                host_wdata;
  logic  [NrLanes-1:0]  lane_bit;

  vec_dispatcher #(
    .NrLanes     (NrLanes),
    .ElemsPerLane(ElemsPerLane)
  ) i_dispatcher (
    .clk_i       (clk_i),      .arst_n_i    (arst_n_i),
    .wb_cyc_i    (wb_cyc_i),   .wb_stb_i    (wb_stb_i),   .wb_we_i  (wb_we_i),
    .wb_adr_i    (wb_adr_i),   .wb_dat_i    (wb_dat_i),   .wb_dat_o (wb_dat_o),
    .wb_ack_o    (wb_ack_o),   .busy_i      (busy),       .issue_o  (issue),
    .issue_op_o  (issue_op),   .issue_vd_o  (issue_vd),
    .issue_vs1_o (issue_vs1),  .issue_vs2_o (issue_vs2),
    .rd_data_i   (rd_data),    .result_i    (result),     .scalar_o (scalar),
    .host_we_o   (host_we),    .host_vreg_o (host_vreg),
    .host_slot_o (host_slot),  .host_wdata_o(host_wdata)
  );

  vec_sequencer #(
    .ElemsPerLane(ElemsPerLane)
  ) i_sequencer (
    .clk_i       (clk_i),      .arst_n_i    (arst_n_i),
    .issue_i     (issue),      .issue_op_i  (issue_op),   .issue_vd_i(issue_vd),
    .issue_vs1_i (issue_vs1),  .issue_vs2_i (issue_vs2),  .busy_o    (busy),
    .ex_valid_o  (ex_valid),   .ex_op_o     (ex_op),      .ex_slot_o (ex_slot),
    .ex_vd_o     (ex_vd),      .ex_vs1_o    (ex_vs1),     .ex_vs2_o  (ex_vs2),
    .ex_last_o   (ex_last)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .ElemsPerLane(ElemsPerLane)
    ) i_lane (
      .clk_i       (clk_i),      .arst_n_i    (arst_n_i),
      .ex_valid_i  (ex_valid),   .ex_op_i     (ex_op),      .ex_slot_i(ex_slot),
      .ex_vd_i     (ex_vd),      .ex_vs1_i    (ex_vs1),     .ex_vs2_i (ex_vs2),
      .scalar_i    (scalar),     .host_we_i   (host_we[l]),
      .host_vreg_i (host_vreg),  .host_slot_i (host_slot),
      .host_wdata_i(host_wdata), .rd_data_o   (rd_data[l]),
      .mask_bit_o  (lane_bit[l])
    );
  end : gen_lanes

  vec_masku #(
    .NrLanes(NrLanes)
  ) i_masku (
    .clk_i     (clk_i),    .arst_n_i  (arst_n_i),
    .ex_valid_i(ex_valid), .ex_op_i   (ex_op),    .ex_last_i(ex_last),
    .lane_bit_i(lane_bit), .result_o  (result)
  );

endmodule : vec_top

/* test/tb_vec_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model of the coprocessor state for the testbench. Included
// in the testbench module body, after NumElems has been declared.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_VEC_MODEL_SVH
`define TB_VEC_MODEL_SVH

// Model register file, indexed by register and element index
elem_t model_vrf [NrVRegs][NumElems];
elem_t model_scalar;
elem_t model_result;

task automatic model_reset();
  for (int r = 0; r < NrVRegs; r++) begin
    for (int e = 0; e < NumElems; e++) begin
      model_vrf[r][e] = '0;
    end
  end
  model_scalar = '0;
  model_result = '0;
endtask

// a is the vs2 element, b the vs1 element or the scalar
function automatic elem_t ref_op(vec_op_e op, elem_t a, elem_t b);
  case (op)
    VADD:    return a + b;
    VSUB:    return a - b;
    VAND:    return a & b;
    VOR:     return a | b;
    VXOR:    return a ^ b;
    VADD_VX: return a + b;
    VMV_VX:  return b;
    VCPOP:   return elem_t'(a[0]);
    default: return a;
  endcase
endfunction

// Element-wise, so vd equal to a source is safe
task automatic model_exec(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2);
  elem_t a;
  elem_t b;
  elem_t count;
  count = '0;
  for (int e = 0; e < NumElems; e++) begin
    a = model_vrf[vs2][e];
    b = (op == VADD_VX || op == VMV_VX) ? model_scalar : model_vrf[vs1][e];
    if (op == VCPOP) begin
      count = count + ref_op(op, a, b);
    end else begin
      model_vrf[vd][e] = ref_op(op, a, b);
    end
  end
  if (op == VCPOP) begin
    model_result = count;
  end
endtask

`endif

/* test/tb_vec_top.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the vector coprocessor. Drives the Wishbone port, keeps
// a reference model and compares every read against it.
////////////////////////////////////////////////////////////////////////////

module tb_vec_top;

  import vec_pkg::*;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned NumElems     = NrLanes * ElemsPerLane;
  localparam int unsigned TotalElems   = NumElems * NrVRegs;
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned DriveDelay   = 2;
  localparam int unsigned NrRandInsns  = 16;
  // Wishbone accesses of all tests
  localparam int unsigned NrAccesses   =
    6 * TotalElems + NrRandInsns * (NumElems + 1) + 2 * NumElems + 3 * NrVRegs + 10;
  localparam int unsigned TimeoutCycles =
    NrAccesses * (ElemsPerLane + 4) + ResetCycles;

  logic     clk;
  logic     arst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  elem_t    wb_dat_w;
  elem_t    wb_dat_r;
  logic     wb_ack;
  int unsigned cycle_count;

  `include "tb_vec_model.svh"

  vec_top #(
    .NrLanes     (NrLanes),
    .ElemsPerLane(ElemsPerLane)
  ) uut (
    .clk_i   (clk),
    .arst_n_i(arst_n),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i (wb_we),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w),
    .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_elem(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_result(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_ack(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles",
                                  TimeoutCycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone host
  ////////////////////////////////////////////////////////////////////////////

  // Callers sit DriveDelay after a rising edge
  task automatic wait_for_ack();
    do begin
      @(posedge clk);
      #DriveDelay;
    end while (!wb_ack);
  endtask

  task automatic wb_write(input wb_addr_t addr, input elem_t data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = addr;
    wb_dat_w = data;
    wait_for_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t addr, output elem_t data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    wait_for_ack();
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Register in address bits 7:5 and element index in bits 4:0
  function automatic wb_addr_t elem_addr(vreg_idx_t r, int unsigned e);
    return AddrElemBase | (wb_addr_t'(r) << 5) | wb_addr_t'(e[4:0]);
  endfunction

  function automatic elem_t insn_word(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1,
                                      vreg_idx_t vs2);
    elem_t w;
    w        = '0;
    w[3:0]   = op;
    w[6:4]   = vd;
    w[9:7]   = vs1;
    w[12:10] = vs2;
    return w;
  endfunction

  task automatic run_insn(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2);
    wb_write(AddrInsn, insn_word(op, vd, vs1, vs2));
    model_exec(op, vd, vs1, vs2);
  endtask

  task automatic write_scalar(input elem_t value);
    wb_write(AddrScalar, value);
    model_scalar = value;
  endtask

  task automatic compare_vreg(input vreg_idx_t r);
    elem_t data;
    for (int e = 0; e < NumElems; e++) begin
      wb_read(elem_addr(r, e), data);
      check_elem($sformatf("v%0d[%0d]", r, e), data, model_vrf[r][e]);
    end
  endtask

  task automatic compare_register_file();
    for (int r = 0; r < NrVRegs; r++) begin
      compare_vreg(vreg_idx_t'(r));
    end
  endtask

  task automatic fill_random();
    elem_t data;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < NumElems; e++) begin
        data = $urandom;
        wb_write(elem_addr(vreg_idx_t'(r), e), data);
        model_vrf[r][e] = data;
      end
    end
  endtask

  task automatic check_status_and_result();
    elem_t data;
    wb_read(AddrResult, data);
    check_result("result", data, model_result);
    wb_read(AddrStatus, data);
    check_result("status", data, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     data;
    elem_t     word;

    void'($urandom(32'h8a95_754a));
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    cycle_count = 0;
    model_reset();
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    arst_n = 1'b1;

    // Reset state
    check_ack("wb_ack_o", wb_ack, 1'b0);
    check_status_and_result();
    compare_register_file();

    // Lane and slot mapping
    fill_random();
    compare_register_file();

    // Scalar broadcast and vector-scalar add
    write_scalar($urandom);
    wb_read(AddrScalar, data);
    check_elem("scalar", data, model_scalar);
    run_insn(VMV_VX, 3'd3, 3'd0, 3'd0);
    compare_vreg(3'd3);
    write_scalar($urandom);
    run_insn(VADD_VX, 3'd5, 3'd0, 3'd1);
    compare_vreg(3'd5);

    // Random vector-vector operations with some in place
    fill_random();
    for (int i = 0; i < NrRandInsns; i++) begin
      op  = vec_op_e'($urandom_range(4, 0));
      vd  = vreg_idx_t'($urandom_range(NrVRegs - 1, 0));
      vs1 = vreg_idx_t'($urandom_range(NrVRegs - 1, 0));
      vs2 = vreg_idx_t'($urandom_range(NrVRegs - 1, 0));
      if (i % 4 == 0) begin
        vd = vs1;
      end else if (i % 4 == 1) begin
        vd = vs2;
      end
      run_insn(op, vd, vs1, vs2);
      compare_vreg(vd);
    end

    // vcpop with the result read right after the instruction ack
    for (int i = 0; i < NrVRegs; i++) begin
      run_insn(VCPOP, 3'd0, 3'd0, vreg_idx_t'(i));
      check_status_and_result();
    end
    compare_register_file();

    // Unused opcode is acked and changes nothing
    word      = insn_word(VADD, 3'd2, 3'd3, 3'd4);
    word[3:0] = 4'hc;
    wb_write(AddrInsn, word);
    check_status_and_result();
    compare_register_file();

    $display("Everything OK");
    $finish;
  end

endmodule : tb_vec_top

/* src.f */
+incdir+test
design/vec_pkg.sv
design/vec_dispatcher.sv
design/vec_sequencer.sv
design/vec_lane.sv
design/vec_masku.sv
design/vec_top.sv
test/tb_vec_top.sv

/* Bender.yml */
package:
  name: vec_top

sources:
  - design/vec_pkg.sv
  - design/vec_dispatcher.sv
  - design/vec_sequencer.sv
  - design/vec_lane.sv
  - design/vec_masku.sv
  - design/vec_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_vec_top.sv
